//--- Makefile
VERILATOR ?= verilator
TOP       ?= clint_tb
FLAGS     ?= --binary --timing
BUILD     ?= obj_dir
FILELIST  ?= filelist.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD)

//--- bench/clint_tb.sv
`timescale 1ns/1ps

module clint_tb;

    localparam int HS_TIMEOUT   = 50;
    localparam int MTIP_TIMEOUT = 400;
    localparam logic RD = 1'b0;
    localparam logic WR = 1'b1;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    typedef enum logic [1:0] {
        MODE_EXACT,
        MODE_WINDOW,
        MODE_NONE
    } mode_e;

    typedef struct packed {
        logic        write;
        logic [15:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp;
        logic [1:0]  resp;
        mode_e       mode;
    } step_t;

    logic                          clk;
    logic                          rst_n;
    logic [clint_pkg::ADDR_W-1:0]  araddr;
    logic                          arvalid;
    logic                          arready;
    logic [clint_pkg::DATA_W-1:0]  rdata;
    clint_pkg::axi_resp_e          rresp;
    logic                          rvalid;
    logic                          rready;
    logic [clint_pkg::ADDR_W-1:0]  awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [clint_pkg::DATA_W-1:0]  wdata;
    logic [clint_pkg::STRB_W-1:0]  wstrb;
    logic                          wvalid;
    logic                          wready;
    clint_pkg::axi_resp_e          bresp;
    logic                          bvalid;
    logic                          bready;
    logic                          mtip;
    logic                          msip;

    step_t        steps[$];
    int           errors;
    int           checks;
    int unsigned  cycle_cnt = 0;
    int unsigned  w_cycle;
    int unsigned  ar_cycle;
    int unsigned  lcg_state;

    clint_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ready delay of 0 to 3 cycles
    function automatic int rand_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]);
    endfunction

    function automatic logic signal_level(input string name);
        case (name)
            "arready": return arready;
            "rvalid":  return rvalid;
            "awready": return awready;
            "wready":  return wready;
            "bvalid":  return bvalid;
            default:   return mtip;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string name);
        $display("timeout while waiting for %s at cycle %0d", name, cycle_cnt);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic wait_high(input string name, input int limit);
        int n;
        n = 0;
        while (!signal_level(name)) begin
            @(negedge clk);
            n++;
            if (n > limit) abort_run(name);
        end
    endtask

    // called and returns on a falling edge
    task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int dly;
        araddr  = addr;
        arvalid = 1'b1;
        wait_high("arready", HS_TIMEOUT);
        @(negedge clk);
        arvalid  = 1'b0;
        ar_cycle = cycle_cnt;
        wait_high("rvalid", HS_TIMEOUT);
        data = rdata;
        resp = rresp;
        dly  = rand_delay();
        repeat (dly) begin
            @(negedge clk);
            check("rvalid", 32'(rvalid), 32'd1);
            check("rdata", rdata, data);
            check("rresp", 32'(rresp), 32'(resp));
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int bdly, output logic [1:0] resp);
        awaddr  = addr;
        awvalid = 1'b1;
        wait_high("awready", HS_TIMEOUT);
        @(negedge clk);
        awvalid = 1'b0;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        wait_high("wready", HS_TIMEOUT);
        @(negedge clk);
        wvalid  = 1'b0;
        w_cycle = cycle_cnt;
        wait_high("bvalid", HS_TIMEOUT);
        resp = bresp;
        repeat (bdly) begin
            @(negedge clk);
            check("bvalid", 32'(bvalid), 32'd1);
            check("bresp", 32'(bresp), 32'(resp));
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic add_step(input logic write, input logic [15:0] addr, input logic [31:0] wd,
                            input logic [3:0] ws, input logic [31:0] exp,
                            input logic [1:0] resp, input mode_e mode);
        steps.push_back(step_t'{write, addr, wd, ws, exp, resp, mode});
    endtask

    task automatic load_table();
        // reset values
        add_step(RD, 16'h0000, 32'h0, 4'h0, 32'h0000_0000, OKAY, MODE_EXACT);
        add_step(RD, 16'h4000, 32'h0, 4'h0, 32'hFFFF_FFFF, OKAY, MODE_EXACT);
        add_step(RD, 16'h4004, 32'h0, 4'h0, 32'hFFFF_FFFF, OKAY, MODE_EXACT);
        // msip set, masked write, clear
        add_step(WR, 16'h0000, 32'hFFFF_FFFF, 4'hF, 32'h0, OKAY, MODE_NONE);
        add_step(RD, 16'h0000, 32'h0, 4'h0, 32'h0000_0001, OKAY, MODE_EXACT);
        add_step(WR, 16'h0000, 32'h0000_0000, 4'b1110, 32'h0, OKAY, MODE_NONE);
        add_step(RD, 16'h0000, 32'h0, 4'h0, 32'h0000_0001, OKAY, MODE_EXACT);
        add_step(WR, 16'h0000, 32'h0000_0000, 4'hF, 32'h0, OKAY, MODE_NONE);
        add_step(RD, 16'h0000, 32'h0, 4'h0, 32'h0000_0000, OKAY, MODE_EXACT);
        // partial strobes on mtimecmp
        add_step(WR, 16'h4000, 32'h1122_3344, 4'b0101, 32'h0, OKAY, MODE_NONE);
        add_step(RD, 16'h4000, 32'h0, 4'h0, 32'hFF22_FF44, OKAY, MODE_EXACT);
        add_step(WR, 16'h4004, 32'hAABB_CCDD, 4'b1000, 32'h0, OKAY, MODE_NONE);
        add_step(RD, 16'h4004, 32'h0, 4'h0, 32'hAAFF_FFFF, OKAY, MODE_EXACT);
        // unmapped address
        add_step(RD, 16'h2000, 32'h0, 4'h0, 32'h0000_0000, SLVERR, MODE_EXACT);
        add_step(WR, 16'h2000, 32'hFFFF_FFFF, 4'hF, 32'h0, SLVERR, MODE_NONE);
        add_step(RD, 16'h0000, 32'h0, 4'h0, 32'h0000_0000, OKAY, MODE_EXACT);
        add_step(RD, 16'h4000, 32'h0, 4'h0, 32'hFF22_FF44, OKAY, MODE_EXACT);
        add_step(RD, 16'h4004, 32'h0, 4'h0, 32'hAAFF_FFFF, OKAY, MODE_EXACT);
        // partial strobes on mtime_hi
        add_step(WR, 16'hBFFC, 32'h1234_5678, 4'b0011, 32'h0, OKAY, MODE_NONE);
        add_step(RD, 16'hBFFC, 32'h0, 4'h0, 32'h0000_5678, OKAY, MODE_EXACT);
        // mtime load, then two reads inside the count window
        add_step(WR, 16'hBFFC, 32'h0000_0000, 4'hF, 32'h0, OKAY, MODE_NONE);
        add_step(WR, 16'hBFF8, 32'h0000_1000, 4'hF, 32'h0, OKAY, MODE_NONE);
        add_step(RD, 16'hBFF8, 32'h0, 4'h0, 32'h0000_1000, OKAY, MODE_WINDOW);
        add_step(RD, 16'hBFF8, 32'h0, 4'h0, 32'h0000_1000, OKAY, MODE_WINDOW);
        add_step(RD, 16'hBFFC, 32'h0, 4'h0, 32'h0000_0000, OKAY, MODE_EXACT);
    endtask

    initial begin
        logic [31:0] rd;
        logic [1:0]  resp;
        logic [31:0] prev_rd;
        logic [31:0] hi_bound;
        logic        have_prev;
        step_t       s;

        lcg_state = 32'd91470;
        errors    = 0;
        checks    = 0;
        have_prev = 1'b0;
        rst_n     = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("mtip", 32'(mtip), 32'd0);
        check("msip", 32'(msip), 32'd0);

        load_table();
        foreach (steps[i]) begin
            s = steps[i];
            if (s.write) begin
                axi_write(s.addr, s.wdata, s.wstrb, rand_delay(), resp);
                check("bresp", 32'(resp), 32'(s.resp));
            end else begin
                axi_read(s.addr, rd, resp);
                check("rresp", 32'(resp), 32'(s.resp));
                if (s.mode == MODE_EXACT) begin
                    check("rdata", rd, s.exp);
                    if (s.addr == 16'h0000) begin
                        check("msip", 32'(msip), s.exp);
                    end
                end else if (s.mode == MODE_WINDOW) begin
                    // at most one tick per MTIME_DIV edges plus one for the phase
                    hi_bound = s.exp + 32'((ar_cycle - w_cycle) / clint_pkg::MTIME_DIV) + 32'd1;
                    checks++;
                    if (rd < s.exp || rd > hi_bound) begin
                        errors++;
                        $display("FAILED rdata 0x%08h outside 0x%08h to 0x%08h",
                                 rd, s.exp, hi_bound);
                    end
                    if (have_prev) begin
                        checks++;
                        if (rd < prev_rd) begin
                            errors++;
                            $display("FAILED rdata 0x%08h below previous read 0x%08h",
                                     rd, prev_rd);
                        end
                    end
                    prev_rd   = rd;
                    have_prev = 1'b1;
                end
            end
        end

        // timer interrupt about 20 ticks ahead
        axi_read(16'hBFF8, rd, resp);
        axi_write(16'h4004, 32'h0000_0000, 4'hF, rand_delay(), resp);
        axi_write(16'h4000, rd + 32'd20, 4'hF, rand_delay(), resp);
        check("mtip", 32'(mtip), 32'd0);
        wait_high("mtip", MTIP_TIMEOUT);
        axi_write(16'h4004, 32'hFFFF_FFFF, 4'hF, 0, resp);
        check("mtip", 32'(mtip), 32'd0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- clint/clint_cmp.sv
`timescale 1ns/1ps

module clint_cmp (
    input  logic                          clk,
    input  logic                          rst_n,
    input  clint_pkg::clint_wr_t          wr,
    input  logic [clint_pkg::TIME_W-1:0]  mtime,
    output logic [clint_pkg::TIME_W-1:0]  mtimecmp,
    output logic                          mtip
);

    localparam int DW = clint_pkg::DATA_W;
    localparam int TW = clint_pkg::TIME_W;

    logic [TW-1:0]  cmp_q;
    logic           mtip_q;
    logic           wr_lo;
    logic           wr_hi;

    assign wr_lo = wr.en && (wr.sel == clint_pkg::REG_MTIMECMP_LO);
    assign wr_hi = wr.en && (wr.sel == clint_pkg::REG_MTIMECMP_HI);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmp_q <= clint_pkg::MTIMECMP_RESET;
        end else if (wr_lo) begin
            cmp_q[DW-1:0] <= clint_pkg::strb_merge(cmp_q[DW-1:0], wr.data, wr.strb);
        end else if (wr_hi) begin
            cmp_q[TW-1:DW] <= clint_pkg::strb_merge(cmp_q[TW-1:DW], wr.data, wr.strb);
        end
    end

    // unsigned compare, registered
    // lags a change in either operand by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtip_q <= 1'b0;
        end else begin
            mtip_q <= (mtime >= cmp_q);
        end
    end

    assign mtimecmp = cmp_q;
    assign mtip     = mtip_q;

endmodule

//--- clint/clint_mtime.sv
`timescale 1ns/1ps

module clint_mtime (
    input  logic                          clk,
    input  logic                          rst_n,
    input  clint_pkg::clint_wr_t          wr,
    output logic [clint_pkg::TIME_W-1:0]  mtime
);

    localparam int DW = clint_pkg::DATA_W;
    localparam int TW = clint_pkg::TIME_W;

    logic [TW-1:0]                  mtime_q;
    logic [clint_pkg::PRESC_W-1:0]  presc_q;
    logic                           tick;
    logic                           wr_lo;
    logic                           wr_hi;

    assign tick  = (presc_q == clint_pkg::PRESC_LAST);
    assign wr_lo = wr.en && (wr.sel == clint_pkg::REG_MTIME_LO);
    assign wr_hi = wr.en && (wr.sel == clint_pkg::REG_MTIME_HI);

    // software write beats the tick and restarts the prescaler
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime_q <= '0;
            presc_q <= '0;
        end else if (wr_lo) begin
            mtime_q[DW-1:0] <= clint_pkg::strb_merge(mtime_q[DW-1:0], wr.data, wr.strb);
            presc_q         <= '0;
        end else if (wr_hi) begin
            mtime_q[TW-1:DW] <= clint_pkg::strb_merge(mtime_q[TW-1:DW], wr.data, wr.strb);
            presc_q          <= '0;
        end else if (tick) begin
            mtime_q <= mtime_q + 1'b1;
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    assign mtime = mtime_q;

endmodule

//--- clint/clint_regmux.sv
`timescale 1ns/1ps

module clint_regmux (
    input  logic                          clk,
    input  logic                          rst_n,
    input  clint_pkg::clint_wr_t          wr,
    input  clint_pkg::clint_reg_e         rd_sel,
    input  logic                          rd_load,
    input  logic [clint_pkg::TIME_W-1:0]  mtime,
    input  logic [clint_pkg::TIME_W-1:0]  mtimecmp,
    output logic [clint_pkg::DATA_W-1:0]  rdata,
    output logic                          msip
);

    localparam int DW = clint_pkg::DATA_W;
    localparam int TW = clint_pkg::TIME_W;

    logic           msip_q;
    logic           wr_msip;
    logic [DW-1:0]  rdata_q;
    logic [DW-1:0]  rd_word;

    // only bit 0 of byte lane 0 is implemented
    assign wr_msip = wr.en && (wr.sel == clint_pkg::REG_MSIP) && wr.strb[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msip_q <= 1'b0;
        end else if (wr_msip) begin
            msip_q <= wr.data[0];
        end
    end

    always_comb begin
        case (rd_sel)
            clint_pkg::REG_MSIP:        rd_word = {{(DW-1){1'b0}}, msip_q};
            clint_pkg::REG_MTIMECMP_LO: rd_word = mtimecmp[DW-1:0];
            clint_pkg::REG_MTIMECMP_HI: rd_word = mtimecmp[TW-1:DW];
            clint_pkg::REG_MTIME_LO:    rd_word = mtime[DW-1:0];
            clint_pkg::REG_MTIME_HI:    rd_word = mtime[TW-1:DW];
            default:                    rd_word = '0;
        endcase
    end

    // held until the next read address handshake
    always_ff @(posedge clk) begin
        if (rd_load) begin
            rdata_q <= rd_word;
        end
    end

    assign rdata = rdata_q;
    assign msip  = msip_q;

endmodule

//--- common/clint_pkg.sv
package clint_pkg;

    // bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int TIME_W = 64;

    // clocks per mtime tick
    localparam int MTIME_DIV = 4;
    localparam int PRESC_W = (MTIME_DIV > 1) ? $clog2(MTIME_DIV) : 1;
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(MTIME_DIV - 1);

    // register map
    localparam logic [ADDR_W-1:0] ADDR_MSIP        = 16'h0000;
    localparam logic [ADDR_W-1:0] ADDR_MTIMECMP_LO = 16'h4000;
    localparam logic [ADDR_W-1:0] ADDR_MTIMECMP_HI = 16'h4004;
    localparam logic [ADDR_W-1:0] ADDR_MTIME_LO    = 16'hBFF8;
    localparam logic [ADDR_W-1:0] ADDR_MTIME_HI    = 16'hBFFC;

    // keeps mtip low out of reset
    localparam logic [TIME_W-1:0] MTIMECMP_RESET = {TIME_W{1'b1}};

    typedef enum logic [2:0] {
        REG_MSIP,
        REG_MTIMECMP_LO,
        REG_MTIMECMP_HI,
        REG_MTIME_LO,
        REG_MTIME_HI,
        REG_NONE
    } clint_reg_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_RESP,
        ST_WRITE_DATA,
        ST_WRITE_RESP
    } ctrl_state_e;

    typedef struct packed {
        logic              en;
        clint_reg_e        sel;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } clint_wr_t;

    // byte lanes with strb set take the new word
    function automatic logic [DATA_W-1:0] strb_merge(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- filelist.f
common/clint_pkg.sv
clint/clint_mtime.sv
clint/clint_cmp.sv
clint/clint_regmux.sv
rtl/axi_lite_clint_ctrl.sv
rtl/clint_top.sv
bench/clint_tb.sv

//--- rtl/axi_lite_clint_ctrl.sv
`timescale 1ns/1ps

module axi_lite_clint_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    // AR
    input  logic [clint_pkg::ADDR_W-1:0]  araddr,
    input  logic                          arvalid,
    output logic                          arready,
    // R
    output clint_pkg::axi_resp_e          rresp,
    output logic                          rvalid,
    input  logic                          rready,
    // AW
    input  logic [clint_pkg::ADDR_W-1:0]  awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    // W
    input  logic [clint_pkg::DATA_W-1:0]  wdata,
    input  logic [clint_pkg::STRB_W-1:0]  wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    // B
    output clint_pkg::axi_resp_e          bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // datapath side
    output clint_pkg::clint_wr_t          wr,
    output clint_pkg::clint_reg_e         rd_sel,
    output logic                          rd_load
);

    clint_pkg::ctrl_state_e  state;
    clint_pkg::clint_reg_e   aw_sel;
    clint_pkg::clint_reg_e   wr_sel_q;
    clint_pkg::axi_resp_e    resp_q;

    function automatic clint_pkg::clint_reg_e decode_addr(
        input logic [clint_pkg::ADDR_W-1:0] addr
    );
        clint_pkg::clint_reg_e sel;
        case (addr)
            clint_pkg::ADDR_MSIP:        sel = clint_pkg::REG_MSIP;
            clint_pkg::ADDR_MTIMECMP_LO: sel = clint_pkg::REG_MTIMECMP_LO;
            clint_pkg::ADDR_MTIMECMP_HI: sel = clint_pkg::REG_MTIMECMP_HI;
            clint_pkg::ADDR_MTIME_LO:    sel = clint_pkg::REG_MTIME_LO;
            clint_pkg::ADDR_MTIME_HI:    sel = clint_pkg::REG_MTIME_HI;
            default:                     sel = clint_pkg::REG_NONE;
        endcase
        return sel;
    endfunction

    function automatic clint_pkg::axi_resp_e resp_for(input clint_pkg::clint_reg_e sel);
        return (sel == clint_pkg::REG_NONE) ? clint_pkg::RESP_SLVERR : clint_pkg::RESP_OKAY;
    endfunction

    assign rd_sel = decode_addr(araddr);
    assign aw_sel = decode_addr(awaddr);

    // a pending read blocks the write address, read wins
    assign arready = (state == clint_pkg::ST_IDLE);
    assign awready = (state == clint_pkg::ST_IDLE) && !arvalid;
    assign wready  = (state == clint_pkg::ST_WRITE_DATA);
    assign rvalid  = (state == clint_pkg::ST_READ_RESP);
    assign bvalid  = (state == clint_pkg::ST_WRITE_RESP);
    assign rresp   = resp_q;
    assign bresp   = resp_q;

    // rdata gets registered on the AR edge
    assign rd_load = arready && arvalid;

    assign wr.en   = wready && wvalid;
    assign wr.sel  = wr_sel_q;
    assign wr.data = wdata;
    assign wr.strb = wstrb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= clint_pkg::ST_IDLE;
        end else begin
            case (state)
                clint_pkg::ST_IDLE: begin
                    if (arvalid) begin
                        state <= clint_pkg::ST_READ_RESP;
                    end else if (awvalid) begin
                        state <= clint_pkg::ST_WRITE_DATA;
                    end
                end
                clint_pkg::ST_READ_RESP: begin
                    if (rready) begin
                        state <= clint_pkg::ST_IDLE;
                    end
                end
                clint_pkg::ST_WRITE_DATA: begin
                    if (wvalid) begin
                        state <= clint_pkg::ST_WRITE_RESP;
                    end
                end
                clint_pkg::ST_WRITE_RESP: begin
                    if (bready) begin
                        state <= clint_pkg::ST_IDLE;
                    end
                end
                default: state <= clint_pkg::ST_IDLE;
            endcase
        end
    end

    // response and write target captured at the address handshake
    always_ff @(posedge clk) begin
        if (rd_load) begin
            resp_q <= resp_for(rd_sel);
        end else if (awready && awvalid) begin
            resp_q   <= resp_for(aw_sel);
            wr_sel_q <= aw_sel;
        end
    end

endmodule

//--- rtl/clint_top.sv
`timescale 1ns/1ps

module clint_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // AR
    input  logic [clint_pkg::ADDR_W-1:0]  araddr,
    input  logic                          arvalid,
    output logic                          arready,
    // R
    output logic [clint_pkg::DATA_W-1:0]  rdata,
    output clint_pkg::axi_resp_e          rresp,
    output logic                          rvalid,
    input  logic                          rready,
    // AW
    input  logic [clint_pkg::ADDR_W-1:0]  awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    // W
    input  logic [clint_pkg::DATA_W-1:0]  wdata,
    input  logic [clint_pkg::STRB_W-1:0]  wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    // B
    output clint_pkg::axi_resp_e          bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // interrupts
    output logic                          mtip,
    output logic                          msip
);

    clint_pkg::clint_wr_t              wr;
    clint_pkg::clint_reg_e             rd_sel;
    logic                              rd_load;
    logic [clint_pkg::TIME_W-1:0]      mtime;
    logic [clint_pkg::TIME_W-1:0]      mtimecmp;

    axi_lite_clint_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr      (wr),
        .rd_sel  (rd_sel),
        .rd_load (rd_load)
    );

    clint_mtime u_mtime (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .mtime (mtime)
    );

    clint_cmp u_cmp (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .mtip     (mtip)
    );

    clint_regmux u_regmux (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .rd_sel   (rd_sel),
        .rd_load  (rd_load),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .rdata    (rdata),
        .msip     (msip)
    );

endmodule
